/* fx3_stream.f */
+incdir+include
design/fx3_stream_pkg.sv
design/fx3_capture_decode.sv
design/stream_out_sequencer.sv
design/fx3_strobe_driver.sv
design/fx3_stream_top.sv
test/fx3_stream_tb.sv

/* Makefile */
sim:
	verilator --binary --timing --top-module fx3_stream_tb -f fx3_stream.f -Mdir obj_dir -o fx3_stream_sim
	./obj_dir/fx3_stream_sim | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* include/fx3_stream_checks.svh */
`ifndef FX3_STREAM_CHECKS_SVH
`define FX3_STREAM_CHECKS_SVH

// compare the fx3 control pins
task automatic check_ctrl(input fx3_stream_pkg::fx3_ctrl_t got,
                          input fx3_stream_pkg::fx3_ctrl_t exp,
                          input string what,
                          inout int errs);
    if (got !== exp) begin
        errs++;
        $display("[ERROR] %s: expected ctrl %b, actual %b at %0t", what, exp, got, $time);
    end
endtask

// led status compare
task automatic check_led(input logic [7:0] got,
                         input logic [7:0] exp,
                         input string what,
                         inout int errs);
    if (got !== exp) begin
        errs++;
        $display("[ERROR] %s: expected led %h, actual %h at %0t", what, exp, got, $time);
    end
endtask

// one fifo word against its expected value
task automatic check_word(input logic [fx3_stream_pkg::FX3_DATA_W-1:0] got,
                          input logic [fx3_stream_pkg::FX3_DATA_W-1:0] exp,
                          input string what,
                          inout int errs);
    if (got !== exp) begin
        errs++;
        $display("[ERROR] %s: expected word %h, actual %h at %0t", what, exp, got, $time);
    end
endtask

// expected led for a state and the registered flags
// idle mirrors flagc on bit 6 and flagd on bit 7
function automatic logic [7:0] expected_led(input fx3_stream_pkg::seq_state_e st,
                                            input fx3_stream_pkg::fx3_flags_t fl);
    logic [7:0] led;
    case (st)
        fx3_stream_pkg::seq_idle: begin
            led = fx3_stream_pkg::LED_IDLE;
            led[6] = fl.c;
            led[7] = fl.d;
        end
        fx3_stream_pkg::seq_lead_in: led = fx3_stream_pkg::LED_LEAD_IN;
        fx3_stream_pkg::seq_stream:  led = fx3_stream_pkg::LED_STREAM;
        fx3_stream_pkg::seq_gap:     led = fx3_stream_pkg::LED_GAP;
        default:                     led = fx3_stream_pkg::LED_FAULT;
    endcase
    return led;
endfunction

`endif

/* test/fx3_stream_tb.sv */
`timescale 1ns/1ps

module fx3_stream_tb;

    import fx3_stream_pkg::*;

    `include "fx3_stream_checks.svh"

    // cycles from start pins true to the first fifo write
    localparam int FIRST_WRITE_LAT = 2 + LEAD_IN_CYCLES + 1;
    localparam int NUM_BURSTS = 4;
    localparam int WATCHDOG_CYCLES =
        NUM_BURSTS * (BURST_WORDS + LEAD_IN_CYCLES + GAP_CYCLES + 20) + 2000;
    localparam fx3_ctrl_t IDLE_CTRL = '{slcs_n: 1'b1, slwr_n: 1'b1, slrd_n: 1'b1,
                                        sloe_n: 1'b1, pktend_n: 1'b1, addr: IDLE_ADDR};
    localparam fx3_ctrl_t STREAM_CTRL = '{slcs_n: 1'b0, slwr_n: 1'b1, slrd_n: 1'b0,
                                          sloe_n: 1'b0, pktend_n: 1'b1, addr: STREAM_OUT_ADDR};

    logic                  usb_clk;
    logic                  rst;
    fx3_flags_t            flags;
    logic [FX3_DATA_W-1:0] bus_word;
    logic                  fifo_empty;
    logic                  fifo_full;
    fx3_ctrl_t             fx3_ctrl;
    logic                  fifo_winc;
    logic [FX3_DATA_W-1:0] fifo_wdata;
    logic [7:0]            led;

    int                    ctrl_errs;
    int                    led_errs;
    int                    word_errs;
    int                    misc_errs;
    int                    run_len;
    int                    last_run;
    int                    write_count;
    logic [FX3_DATA_W-1:0] exp_word;
    integer                seed;

    fx3_stream_top uut (
        .usb_clk      (usb_clk),
        .rst          (rst),
        .fx3_flags_i  (flags),
        .fx3_data_i   (bus_word),
        .fifo_empty_i (fifo_empty),
        .fifo_full_i  (fifo_full),
        .fx3_ctrl_o   (fx3_ctrl),
        .fifo_winc_o  (fifo_winc),
        .fifo_wdata_o (fifo_wdata),
        .led_o        (led)
    );

    always #5 usb_clk = ~usb_clk;

    // fx3 bus model with a new word every cycle
    always @(posedge usb_clk) begin
        #1;
        bus_word <= bus_word + 16'd1;
    end

    // fifo side compare sampled mid-cycle
    // wdata is the bus word from two edges back
    always @(negedge usb_clk) begin
        if (!rst) begin
            run_len = 0;
        end else if (fifo_winc) begin
            if (run_len == 0) begin
                exp_word = bus_word - 16'd2;
                check_word(fifo_wdata, exp_word, "first word", word_errs);
            end else begin
                exp_word = exp_word + 16'd1;
                check_word(fifo_wdata, exp_word, "next word", word_errs);
            end
            check_ctrl(fx3_ctrl, STREAM_CTRL, "ctrl during write", ctrl_errs);
            check_led(led, expected_led(seq_stream, flags), "led during write", led_errs);
            run_len++;
            write_count++;
        end else if (run_len != 0) begin
            // burst just ended so keep its length
            last_run = run_len;
            run_len = 0;
        end
    end

    task automatic next_cycle();
        @(posedge usb_clk);
        #1;
    endtask

    task automatic expect_count(input string what, input int exp, input int got);
        if (got != exp) begin
            misc_errs++;
            $display("[ERROR] %s: expected %0d, actual %0d", what, exp, got);
        end
    endtask

    // cycles from now to the first write
    task automatic wait_first_write(input string what, output int cycles);
        cycles = 0;
        do begin
            next_cycle();
            cycles++;
        end while (!fifo_winc && cycles < FIRST_WRITE_LAT + GAP_CYCLES + 20);
        if (!fifo_winc) begin
            misc_errs++;
            $display("%s: no FIFO write arrived after start", what);
        end
    endtask

    // returns mid-cycle once writes stop
    task automatic wait_burst_end(input string what);
        int n;
        n = 0;
        do begin
            @(negedge usb_clk);
            #1;
            n++;
        end while (fifo_winc && n < BURST_WORDS + 8);
        if (fifo_winc) begin
            misc_errs++;
            $display("%s: FIFO writes kept going past a full burst", what);
        end
    endtask

    // one start condition missing and the fx3 must stay released
    task automatic hold_blocked(input string what, input logic empty, input logic flag_c);
        int len;
        len = 8 + ($random(seed) & 31);
        fifo_empty = empty;
        flags.c = flag_c;
        for (int i = 0; i < len; i++) begin
            next_cycle();
            check_ctrl(fx3_ctrl, IDLE_CTRL, what, ctrl_errs);
            // flags reach the leds two edges later
            if (i >= 2) begin
                check_led(led, expected_led(seq_idle, flags), what, led_errs);
            end
            if (fifo_winc) begin
                misc_errs++;
                $display("%s: FIFO written while start was blocked", what);
            end
        end
    endtask

    initial begin
        int   lat;
        int   gap;
        int   stall_at;
        int   writes_at_fault;
        logic stopped;
        usb_clk = 1'b0;
        rst = 1'b0;
        seed = 1;
        bus_word = '0;
        flags = '{a: 1'b0, b: 1'b0, c: 1'b1, d: 1'b1};
        fifo_empty = 1'b0;
        fifo_full = 1'b0;
        ctrl_errs = 0;
        led_errs = 0;
        word_errs = 0;
        misc_errs = 0;
        run_len = 0;
        last_run = 0;
        write_count = 0;
        exp_word = '0;
        repeat (10) @(posedge usb_clk);
        #1;
        rst = 1'b1;
        check_ctrl(fx3_ctrl, IDLE_CTRL, "reset", ctrl_errs);
        check_led(led, LED_IDLE, "reset", led_errs);
        expect_count("reset winc", 0, int'(fifo_winc));
        repeat (3) next_cycle();
        check_led(led, expected_led(seq_idle, flags), "idle flags", led_errs);
        hold_blocked("fifo not empty", 1'b0, 1'b1);
        hold_blocked("no data on flagc", 1'b1, 1'b0);
        // first burst from idle
        flags.c = 1'b1;
        wait_first_write("burst 1", lat);
        expect_count("burst 1 latency", FIRST_WRITE_LAT, lat);
        wait_burst_end("burst 1");
        expect_count("burst 1 length", BURST_WORDS, last_run);
        check_led(led, expected_led(seq_gap, flags), "gap", led_errs);
        // start stays true and only the gap holds off the next burst
        gap = 0;
        while (fx3_ctrl.slcs_n && gap < 4 * GAP_CYCLES) begin
            gap++;
            next_cycle();
        end
        if (gap < GAP_CYCLES) begin
            misc_errs++;
            $display("[ERROR] gap: expected at least %0d, actual %0d", GAP_CYCLES, gap);
        end
        wait_first_write("burst 2", lat);
        wait_burst_end("burst 2");
        expect_count("burst 2 length", BURST_WORDS, last_run);
        // third burst overflows the line fifo
        wait_first_write("burst 3", lat);
        stall_at = 16 + ($random(seed) & 2047);
        repeat (stall_at) next_cycle();
        fifo_full = 1'b1;
        stopped = 1'b0;
        for (int i = 0; i < 3 && !stopped; i++) begin
            next_cycle();
            stopped = !fifo_winc && fx3_ctrl.slcs_n && fx3_ctrl.slrd_n && fx3_ctrl.sloe_n;
        end
        if (!stopped) begin
            misc_errs++;
            $display("overflow: writes and strobes still active 3 cycles after full");
        end
        check_ctrl(fx3_ctrl, IDLE_CTRL, "fault ctrl", ctrl_errs);
        check_led(led, LED_FAULT, "fault", led_errs);
        // fault is latched even with start true again
        fifo_full = 1'b0;
        writes_at_fault = write_count;
        repeat (40) begin
            next_cycle();
            check_led(led, LED_FAULT, "fault hold", led_errs);
        end
        expect_count("writes during fault", writes_at_fault, write_count);
        rst = 1'b0;
        repeat (10) next_cycle();
        rst = 1'b1;
        wait_first_write("after reset", lat);
        expect_count("after reset latency", FIRST_WRITE_LAT, lat);
        wait_burst_end("after reset");
        expect_count("after reset length", BURST_WORDS, last_run);
        $display("errors: ctrl %0d, led %0d, word %0d, other %0d",
                 ctrl_errs, led_errs, word_errs, misc_errs);
        if (ctrl_errs + led_errs + word_errs + misc_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // bounded by the burst count
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge usb_clk);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("errors: ctrl %0d, led %0d, word %0d, other %0d",
                 ctrl_errs, led_errs, word_errs, misc_errs);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* design/fx3_stream_top.sv */
`timescale 1ns/1ps

module fx3_stream_top (
    input  logic                                  usb_clk,
    input  logic                                  rst,
    input  fx3_stream_pkg::fx3_flags_t            fx3_flags_i,
    input  logic [fx3_stream_pkg::FX3_DATA_W-1:0] fx3_data_i,
    input  logic                                  fifo_empty_i,
    input  logic                                  fifo_full_i,
    output fx3_stream_pkg::fx3_ctrl_t             fx3_ctrl_o,
    output logic                                  fifo_winc_o,
    output logic [fx3_stream_pkg::FX3_DATA_W-1:0] fifo_wdata_o,
    output logic [7:0]                            led_o
);

    import fx3_stream_pkg::*;

    // decode to sequencer
    stream_cmd_t           cmd;
    // decode to driver
    fx3_flags_t            flags;
    logic [FX3_DATA_W-1:0] data;
    // sequencer to driver
    seq_state_e            state;
    logic                  rd_en;

    // pins in, registered flags, word and commands out
    fx3_capture_decode u_decode (
        .usb_clk      (usb_clk),
        .rst          (rst),
        .fx3_flags_i  (fx3_flags_i),
        .fx3_data_i   (fx3_data_i),
        .fifo_empty_i (fifo_empty_i),
        .fifo_full_i  (fifo_full_i),
        .cmd_o        (cmd),
        .flags_o      (flags),
        .data_o       (data)
    );

    // master mode fsm
    stream_out_sequencer u_seq (
        .usb_clk (usb_clk),
        .rst     (rst),
        .cmd_i   (cmd),
        .state_o (state),
        .rd_en_o (rd_en)
    );

    // registered strobes toward fx3, fifo and leds
    fx3_strobe_driver u_drive (
        .usb_clk      (usb_clk),
        .rst          (rst),
        .state_i      (state),
        .rd_en_i      (rd_en),
        .flags_i      (flags),
        .data_i       (data),
        .fx3_ctrl_o   (fx3_ctrl_o),
        .fifo_winc_o  (fifo_winc_o),
        .fifo_wdata_o (fifo_wdata_o),
        .led_o        (led_o)
    );

endmodule

/* design/fx3_strobe_driver.sv */
`timescale 1ns/1ps

module fx3_strobe_driver (
    input  logic                                  usb_clk,
    input  logic                                  rst,
    input  fx3_stream_pkg::seq_state_e            state_i,
    input  logic                                  rd_en_i,
    input  fx3_stream_pkg::fx3_flags_t            flags_i,
    input  logic [fx3_stream_pkg::FX3_DATA_W-1:0] data_i,
    output fx3_stream_pkg::fx3_ctrl_t             fx3_ctrl_o,
    output logic                                  fifo_winc_o,
    output logic [fx3_stream_pkg::FX3_DATA_W-1:0] fifo_wdata_o,
    output logic [7:0]                            led_o
);

    import fx3_stream_pkg::*;

    fx3_ctrl_t  ctrl_d;
    logic [7:0] led_d;
    logic       selected;

    // chip select and stream-out socket only during lead-in and stream
    // gap and fault release the fx3
    assign selected = (state_i == seq_lead_in) || (state_i == seq_stream);

    always_comb begin
        ctrl_d.slcs_n = !selected;
        ctrl_d.addr = selected ? STREAM_OUT_ADDR : IDLE_ADDR;
        ctrl_d.slrd_n = !rd_en_i;
        ctrl_d.sloe_n = !rd_en_i;
        // no write path, both held inactive
        ctrl_d.slwr_n = 1'b1;
        ctrl_d.pktend_n = 1'b1;
    end

    // led code per state
    always_comb begin
        case (state_i)
            seq_idle: begin
                led_d = LED_IDLE;
                // show what the fx3 is reporting while waiting
                led_d[6] = flags_i.c;
                led_d[7] = flags_i.d;
            end
            seq_lead_in: led_d = LED_LEAD_IN;
            seq_stream:  led_d = LED_STREAM;
            seq_gap:     led_d = LED_GAP;
            default:     led_d = LED_FAULT;
        endcase
    end

    // pin side registers
    always_ff @(posedge usb_clk or negedge rst) begin
        if (!rst) begin
            fx3_ctrl_o <= '{slcs_n: 1'b1, slwr_n: 1'b1, slrd_n: 1'b1, sloe_n: 1'b1,
                            pktend_n: 1'b1, addr: IDLE_ADDR};
            fifo_winc_o <= 1'b0;
            led_o <= LED_IDLE;
        end else begin
            fx3_ctrl_o <= ctrl_d;
            fifo_winc_o <= rd_en_i;
            led_o <= led_d;
        end
    end

    // word lines up with fifo_winc_o
    always_ff @(posedge usb_clk) begin
        fifo_wdata_o <= data_i;
    end

endmodule

/* design/stream_out_sequencer.sv */
`timescale 1ns/1ps

module stream_out_sequencer (
    input  logic                        usb_clk,
    input  logic                        rst,
    input  fx3_stream_pkg::stream_cmd_t cmd_i,
    output fx3_stream_pkg::seq_state_e  state_o,
    output logic                        rd_en_o
);

    import fx3_stream_pkg::*;

    // reload values for the shared down counter
    localparam logic [CNT_W-1:0] LEAD_IN_LOAD = CNT_W'(LEAD_IN_CYCLES - 1);
    localparam logic [CNT_W-1:0] BURST_LOAD = CNT_W'(BURST_WORDS - 1);
    localparam logic [CNT_W-1:0] GAP_LOAD = CNT_W'(GAP_CYCLES - 1);

    seq_state_e       state_q;
    seq_state_e       state_d;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_d;
    logic             cnt_done;

    // last cycle of the current timed phase
    assign cnt_done = (cnt_q == '0);

    always_comb begin
        state_d = state_q;
        cnt_d = cnt_q;
        case (state_q)
            seq_idle: begin
                // start only counts while idle
                if (cmd_i.start) begin
                    state_d = seq_lead_in;
                    cnt_d = LEAD_IN_LOAD;
                end
            end
            seq_lead_in: begin
                // socket selected, waiting before the first read
                if (cnt_done) begin
                    state_d = seq_stream;
                    cnt_d = BURST_LOAD;
                end else begin
                    cnt_d = cnt_q - 1'b1;
                end
            end
            seq_stream: begin
                // full fifo wins over the word count
                if (cmd_i.stall) begin
                    state_d = seq_fault;
                end else if (cnt_done) begin
                    state_d = seq_gap;
                    cnt_d = GAP_LOAD;
                end else begin
                    cnt_d = cnt_q - 1'b1;
                end
            end
            seq_gap: begin
                if (cnt_done) begin
                    state_d = seq_idle;
                end else begin
                    cnt_d = cnt_q - 1'b1;
                end
            end
            seq_fault: begin
                // latched, only rst gets out of here
                state_d = seq_fault;
            end
            default: begin
                state_d = seq_idle;
            end
        endcase
    end

    always_ff @(posedge usb_clk or negedge rst) begin
        if (!rst) begin
            state_q <= seq_idle;
            cnt_q <= '0;
        end else begin
            state_q <= state_d;
            cnt_q <= cnt_d;
        end
    end

    assign state_o = state_q;
    // reads run for the whole stream state
    assign rd_en_o = (state_q == seq_stream);

endmodule

/* design/fx3_capture_decode.sv */
`timescale 1ns/1ps

module fx3_capture_decode (
    input  logic                                  usb_clk,
    input  logic                                  rst,
    input  fx3_stream_pkg::fx3_flags_t            fx3_flags_i,
    input  logic [fx3_stream_pkg::FX3_DATA_W-1:0] fx3_data_i,
    input  logic                                  fifo_empty_i,
    input  logic                                  fifo_full_i,
    output fx3_stream_pkg::stream_cmd_t           cmd_o,
    output fx3_stream_pkg::fx3_flags_t            flags_o,
    output logic [fx3_stream_pkg::FX3_DATA_W-1:0] data_o
);

    // flags come straight off the fx3 pins
    // one flop stage before anything downstream looks at them
    always_ff @(posedge usb_clk or negedge rst) begin
        if (!rst) begin
            flags_o <= '0;
        end else begin
            flags_o <= fx3_flags_i;
        end
    end

    // command register, one cycle from pin to command
    // start needs an empty line fifo and data waiting on flagc
    // stall is simply the downstream full flag
    always_ff @(posedge usb_clk or negedge rst) begin
        if (!rst) begin
            cmd_o <= '0;
        end else begin
            cmd_o.start <= fifo_empty_i && fx3_flags_i.c;
            cmd_o.stall <= fifo_full_i;
        end
    end

    // bus word capture
    // sampled every cycle, only used while the read strobe is active
    always_ff @(posedge usb_clk) begin
        data_o <= fx3_data_i;
    end

endmodule

/* design/fx3_stream_pkg.sv */
package fx3_stream_pkg;

    // width of the fx3 data bus and the downstream fifo word
    localparam int FX3_DATA_W = 16;

    // words per stream-out burst
    localparam int BURST_WORDS = 4096;
    // socket select to first read
    localparam int LEAD_IN_CYCLES = 6;
    // idle time after a burst
    localparam int GAP_CYCLES = 10;
    // shared counter, wide enough for a full burst
    localparam int CNT_W = 13;

    // fx3 socket addresses on A1..A0
    localparam logic [1:0] STREAM_OUT_ADDR = 2'd3;
    localparam logic [1:0] IDLE_ADDR = 2'd2;

    // led status codes
    localparam logic [7:0] LED_IDLE = 8'd0;
    localparam logic [7:0] LED_LEAD_IN = 8'd2;
    localparam logic [7:0] LED_STREAM = 8'd3;
    localparam logic [7:0] LED_GAP = 8'd4;
    localparam logic [7:0] LED_FAULT = 8'd15;

    // fx3 slave fifo flags
    typedef struct packed {
        logic a;
        logic b;
        // c is data ready on the stream-out socket
        logic c;
        logic d;
    } fx3_flags_t;

    // fx3 control pins, all strobes active low
    typedef struct packed {
        logic       slcs_n;
        logic       slwr_n;
        logic       slrd_n;
        logic       sloe_n;
        logic       pktend_n;
        logic [1:0] addr;
    } fx3_ctrl_t;

    // commands from decode to the sequencer
    typedef struct packed {
        logic start;
        logic stall;
    } stream_cmd_t;

    // master mode states
    typedef enum logic [2:0] {
        seq_idle    = 3'd0,
        seq_lead_in = 3'd1,
        seq_stream  = 3'd2,
        seq_gap     = 3'd3,
        seq_fault   = 3'd4
    } seq_state_e;

endpackage
